//--- hdl/cmd_parser.sv
`timescale 1ns/10ps
module cmd_parser
  import memreq_pkg::*;
(
  input  logic        bus_clock,
  input  logic        bus_reset,
  input  logic        s_valid_i,
  input  logic [7:0]  s_data_i,
  input  logic        s_last_i,
  output logic        s_ready_o,
  output logic        hdr_valid_o,
  output logic        hdr_write_o,
  output mem_header_u hdr_o,
  input  logic        hdr_ready_i,
  output logic        wb_valid_o,
  output logic [7:0]  wb_data_o,
  output logic        wb_last_o,
  input  logic        wb_ready_i
);

  logic [1:0] state_q, state_d;
  logic [4:0] ptr_q;  // One-hot over header bytes 1 to 5
  logic take_q;  // Open for command and header bytes
  logic write_q;
  mem_header_u hdr_q;
  logic s_fire;

  assign s_ready_o = (state_q == ps_data) ? wb_ready_i : take_q;
  assign s_fire = s_valid_i && s_ready_o;

  assign hdr_valid_o = (state_q == ps_wait);
  assign hdr_write_o = write_q;
  assign hdr_o = hdr_q;

  // STORE payload goes straight on to the packer
  assign wb_valid_o = (state_q == ps_data) && s_valid_i;
  assign wb_data_o = s_data_i;
  assign wb_last_o = s_last_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ps_cmd: begin
        if (s_fire)
          state_d = ps_hdr;
      end
      ps_hdr: begin
        if (s_fire && ptr_q[4])
          state_d = ps_wait;
      end
      ps_wait: begin
        if (hdr_ready_i)
          state_d = write_q ? ps_data : ps_cmd;
      end
      default: begin
        if (s_fire && s_last_i)
          state_d = ps_cmd;
      end
    endcase
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= ps_cmd;
      take_q <= 1'b0;
      ptr_q <= '0;
    end else begin
      state_q <= state_d;
      take_q <= (state_d == ps_cmd) || (state_d == ps_hdr);
      if (s_fire && state_q == ps_cmd)
        ptr_q <= 5'b00001;
      else if (s_fire && state_q == ps_hdr)
        ptr_q <= {ptr_q[3:0], 1'b0};
    end
  end

  always_ff @(posedge bus_clock) begin
    if (s_fire && state_q == ps_cmd)
      write_q <= ~s_data_i[7];  // Bit 7 set means FETCH
    if (s_fire && state_q == ps_hdr) begin
      for (int i = 0; i < 5; i++) begin
        if (ptr_q[i])
          hdr_q.bytes[i] <= s_data_i;
      end
    end
  end

  // Only a FETCH may end on header byte 5
  a_no_early_last: assert property (@(posedge bus_clock) disable iff (bus_reset)
    s_fire && (state_q == ps_cmd || (state_q == ps_hdr && (!ptr_q[4] || write_q)))
    |-> !s_last_i);

endmodule

//--- hdl/mem_requester.sv
`timescale 1ns/10ps
module mem_requester
  import memreq_pkg::*;
(
  input  logic                   bus_clock,
  input  logic                   bus_reset,
  input  logic                   hdr_valid_i,
  input  logic                   hdr_write_i,
  input  mem_header_u            hdr_i,
  output logic                   hdr_ready_o,
  input  logic                   wd_valid_i,
  input  logic [word_width-1:0]  wd_data_i,
  input  logic                   wd_last_i,
  output logic                   wd_ready_o,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [addr_width-1:0]  mem_addr_o,
  output logic [word_width-1:0]  mem_wdata_o,
  input  logic                   mem_gnt_i,
  output logic                   job_valid_o,
  output logic                   job_write_o,
  output logic [id_width-1:0]    job_id_o,
  output logic [beats_width-1:0] job_beats_o,
  input  logic                   rsp_pop_i,
  input  logic                   job_done_i
);

  logic state_q;
  logic job_q;
  logic req_q;
  logic we_q;
  logic write_q;
  logic [id_width-1:0] id_q;
  logic [beats_width-1:0] beats_q;
  logic [beats_width:0] left_q;  // Beats not yet issued
  logic [addr_width-1:0] next_q;  // Address of the next beat
  logic [addr_width-1:0] addr_q;
  logic [word_width-1:0] wdata_q;
  logic [out_width-1:0] out_q;  // Read beats granted but not popped
  logic hdr_fire, slot_free, credit_ok, issue_rd, issue_wr, issue;
  logic rd_gnt;
  logic [addr_width-1:0] issue_addr;

  assign hdr_ready_o = (state_q == rq_idle);
  assign hdr_fire = hdr_valid_i && hdr_ready_o;

  assign slot_free = !req_q || mem_gnt_i;
  assign credit_ok = (out_q + req_q) < max_outstanding;  // Held request counts too

  assign wd_ready_o = (state_q == rq_run) && write_q && (left_q != '0) && slot_free;
  assign issue_wr = wd_ready_o && wd_valid_i;
  // First read beat goes out together with the header
  assign issue_rd = (hdr_fire && !hdr_write_i) ||
                    ((state_q == rq_run) && !write_q && (left_q != '0) && slot_free && credit_ok);
  assign issue = issue_wr || issue_rd;
  assign issue_addr = hdr_fire ? hdr_i.fields.addr : next_q;
  assign rd_gnt = req_q && mem_gnt_i && !we_q;

  assign mem_req_o = req_q;
  assign mem_we_o = we_q;
  assign mem_addr_o = addr_q;
  assign mem_wdata_o = wdata_q;

  assign job_valid_o = job_q;
  assign job_write_o = write_q;
  assign job_id_o = id_q;
  assign job_beats_o = beats_q;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= rq_idle;
      job_q <= 1'b0;
      req_q <= 1'b0;
      left_q <= '0;
      out_q <= '0;
    end else begin
      job_q <= hdr_fire;
      if (hdr_fire) begin
        state_q <= rq_run;
        left_q <= hdr_write_i ? {1'b0, hdr_i.fields.beats} + 1'b1 : {1'b0, hdr_i.fields.beats};
      end else if (issue) begin
        left_q <= left_q - 1'b1;
      end
      if (state_q == rq_run && job_done_i)
        state_q <= rq_idle;  // Framer has sent the whole response
      if (issue)
        req_q <= 1'b1;
      else if (mem_gnt_i)
        req_q <= 1'b0;
      if (rd_gnt && !(rsp_pop_i && !write_q))
        out_q <= out_q + 1'b1;
      else if (!rd_gnt && rsp_pop_i && !write_q)
        out_q <= out_q - 1'b1;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (hdr_fire) begin
      write_q <= hdr_write_i;
      id_q <= hdr_i.fields.id;
      beats_q <= hdr_i.fields.beats;
    end
    if (issue) begin
      we_q <= issue_wr;
      addr_q <= issue_addr;
      wdata_q <= wd_data_i;
      next_q <= issue_addr + 1'b1;
    end else if (hdr_fire) begin
      next_q <= hdr_i.fields.addr;
    end
  end

  // Framer pops keep the credit count inside the FIFO depth
  a_credit_limit: assert property (@(posedge bus_clock) disable iff (bus_reset)
    out_q <= max_outstanding);

  // Packed payload length agrees with the header beat count
  a_wd_last: assert property (@(posedge bus_clock) disable iff (bus_reset)
    wd_valid_i && wd_ready_o |-> wd_last_i == (left_q == 1));

endmodule

//--- hdl/memreq_pkg.sv
package memreq_pkg;

  localparam int addr_width = 28;  // Word address
  localparam int id_width = 4;
  localparam int word_width = 32;
  localparam int beats_width = 8;  // Holds beat count minus one
  localparam int max_outstanding = 4;  // Read credits and framer FIFO depth

  localparam int out_width = $clog2(max_outstanding + 1);
  localparam int fifo_aw = $clog2(max_outstanding);

  // Request and response codes on the byte streams
  localparam logic [7:0] cmd_store = 8'h01;
  localparam logic [7:0] cmd_wdone = 8'h02;
  localparam logic [7:0] cmd_wfail = 8'h03;
  localparam logic [7:0] cmd_fetch = 8'h80;
  localparam logic [7:0] cmd_rdata = 8'h81;
  localparam logic [7:0] cmd_rfail = 8'h82;

  // Parser states
  localparam logic [1:0] ps_cmd = 2'd0;
  localparam logic [1:0] ps_hdr = 2'd1;
  localparam logic [1:0] ps_wait = 2'd2;
  localparam logic [1:0] ps_data = 2'd3;

  // Requester states
  localparam logic rq_idle = 1'b0;
  localparam logic rq_run = 1'b1;

  // Framer states
  localparam logic [2:0] fr_idle = 3'd0;
  localparam logic [2:0] fr_drain = 3'd1;
  localparam logic [2:0] fr_stat = 3'd2;
  localparam logic [2:0] fr_id = 3'd3;
  localparam logic [2:0] fr_data = 3'd4;

  // Header bytes 1 to 5 of a packet, raw and decoded
  typedef union packed {
    logic [4:0][7:0] bytes;  // bytes[0] is the beat count byte
    struct packed {
      logic [id_width-1:0] id;  // Top nibble of the last byte
      logic [addr_width-1:0] addr;
      logic [beats_width-1:0] beats;
    } fields;
  } mem_header_u;

endpackage

//--- hdl/memreq_top.sv
`timescale 1ns/10ps
module memreq_top
  import memreq_pkg::*;
(
  input  logic                  bus_clock,
  input  logic                  bus_reset,
  input  logic                  s_valid_i,
  input  logic [7:0]            s_data_i,
  input  logic                  s_last_i,
  output logic                  s_ready_o,
  output logic                  m_valid_o,
  output logic [7:0]            m_data_o,
  output logic                  m_last_o,
  input  logic                  m_ready_i,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [addr_width-1:0] mem_addr_o,
  output logic [word_width-1:0] mem_wdata_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  logic [word_width-1:0] mem_rdata_i,
  input  logic                  mem_err_i
);

  logic hdr_valid, hdr_write, hdr_ready;
  mem_header_u hdr;
  logic wb_valid, wb_ready, wb_last;
  logic [7:0] wb_data;
  logic wd_valid, wd_ready, wd_last;
  logic [word_width-1:0] wd_data;
  logic job_valid, job_write;  // Start of a transaction
  logic [id_width-1:0] job_id;
  logic [beats_width-1:0] job_beats;
  logic rsp_pop, job_done;

  cmd_parser u_parser (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .s_valid_i(s_valid_i), .s_data_i(s_data_i), .s_last_i(s_last_i), .s_ready_o(s_ready_o),
    .hdr_valid_o(hdr_valid), .hdr_write_o(hdr_write), .hdr_o(hdr), .hdr_ready_i(hdr_ready),
    .wb_valid_o(wb_valid), .wb_data_o(wb_data), .wb_last_o(wb_last), .wb_ready_i(wb_ready)
  );

  word_packer u_packer (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .wb_valid_i(wb_valid), .wb_data_i(wb_data), .wb_last_i(wb_last), .wb_ready_o(wb_ready),
    .wd_valid_o(wd_valid), .wd_data_o(wd_data), .wd_last_o(wd_last), .wd_ready_i(wd_ready)
  );

  mem_requester u_requester (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .hdr_valid_i(hdr_valid), .hdr_write_i(hdr_write), .hdr_i(hdr), .hdr_ready_o(hdr_ready),
    .wd_valid_i(wd_valid), .wd_data_i(wd_data), .wd_last_i(wd_last), .wd_ready_o(wd_ready),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
    .mem_wdata_o(mem_wdata_o), .mem_gnt_i(mem_gnt_i),
    .job_valid_o(job_valid), .job_write_o(job_write), .job_id_o(job_id),
    .job_beats_o(job_beats),
    .rsp_pop_i(rsp_pop), .job_done_i(job_done)
  );

  resp_framer u_framer (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .job_valid_i(job_valid), .job_write_i(job_write), .job_id_i(job_id),
    .job_beats_i(job_beats),
    .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i), .mem_err_i(mem_err_i),
    .rsp_pop_o(rsp_pop), .job_done_o(job_done),
    .m_valid_o(m_valid_o), .m_data_o(m_data_o), .m_last_o(m_last_o), .m_ready_i(m_ready_i)
  );

endmodule

//--- hdl/resp_framer.sv
`timescale 1ns/10ps
module resp_framer
  import memreq_pkg::*;
(
  input  logic                   bus_clock,
  input  logic                   bus_reset,
  input  logic                   job_valid_i,
  input  logic                   job_write_i,
  input  logic [id_width-1:0]    job_id_i,
  input  logic [beats_width-1:0] job_beats_i,
  input  logic                   mem_rvalid_i,
  input  logic [word_width-1:0]  mem_rdata_i,
  input  logic                   mem_err_i,
  output logic                   rsp_pop_o,
  output logic                   job_done_o,
  output logic                   m_valid_o,
  output logic [7:0]             m_data_o,
  output logic                   m_last_o,
  input  logic                   m_ready_i
);

  logic [2:0] state_q;
  logic [1:0] sel_q;  // Byte lane of the head word
  logic write_q;
  logic err_q;  // OR of write beat errors
  logic [id_width-1:0] id_q;
  logic [beats_width-1:0] left_q;  // Beats left after the head
  logic [word_width:0] fifo_mem [max_outstanding];  // {err, data}
  logic [fifo_aw-1:0] wr_ptr_q, rd_ptr_q;
  logic [out_width-1:0] count_q;
  logic empty, full, m_fire, last_beat, drain_pop, data_pop;
  logic head_err;
  logic [word_width-1:0] head_data;

  assign empty = (count_q == '0);
  assign full = (count_q == max_outstanding);
  assign {head_err, head_data} = fifo_mem[rd_ptr_q];
  assign last_beat = (left_q == '0);
  assign m_fire = m_valid_o && m_ready_i;

  assign drain_pop = (state_q == fr_drain) && !empty;
  assign data_pop = (state_q == fr_data) && m_fire && (sel_q == 2'd3);
  assign rsp_pop_o = drain_pop || data_pop;
  assign job_done_o = m_fire && m_last_o;

  always_comb begin
    m_valid_o = 1'b0;
    m_data_o = {{(8 - id_width){1'b0}}, id_q};
    m_last_o = 1'b0;
    case (state_q)
      fr_stat: begin
        m_valid_o = write_q || !empty;  // Read status waits for the first beat
        if (write_q)
          m_data_o = err_q ? cmd_wfail : cmd_wdone;
        else
          m_data_o = head_err ? cmd_rfail : cmd_rdata;
      end
      fr_id: begin
        m_valid_o = 1'b1;
        m_last_o = write_q;
      end
      fr_data: begin
        m_valid_o = !empty;
        m_data_o = head_data[sel_q*8 +: 8];
        m_last_o = last_beat && (sel_q == 2'd3);
      end
      default: ;
    endcase
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= fr_idle;
      sel_q <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      case (state_q)
        fr_idle: begin
          if (job_valid_i)
            state_q <= job_write_i ? fr_drain : fr_stat;
        end
        fr_drain: begin
          if (drain_pop && last_beat)
            state_q <= fr_stat;
        end
        fr_stat: begin
          if (m_fire)
            state_q <= fr_id;
        end
        fr_id: begin
          if (m_fire) begin
            state_q <= write_q ? fr_idle : fr_data;
            sel_q <= '0;
          end
        end
        fr_data: begin
          if (m_fire) begin
            sel_q <= sel_q + 2'd1;
            if (sel_q == 2'd3 && last_beat)
              state_q <= fr_idle;
          end
        end
        default: state_q <= fr_idle;
      endcase
      if (mem_rvalid_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rsp_pop_o)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (mem_rvalid_i && !rsp_pop_o)
        count_q <= count_q + 1'b1;
      else if (!mem_rvalid_i && rsp_pop_o)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (mem_rvalid_i)
      fifo_mem[wr_ptr_q] <= {mem_err_i, mem_rdata_i};
    if (state_q == fr_idle && job_valid_i) begin
      write_q <= job_write_i;
      id_q <= job_id_i;
      left_q <= job_beats_i;
      err_q <= 1'b0;
    end else if (drain_pop) begin
      err_q <= err_q | head_err;
      left_q <= left_q - 1'b1;
    end else if (data_pop) begin
      left_q <= left_q - 1'b1;
    end
  end

  // Read credits in the requester keep the buffer from overflowing
  a_no_overflow: assert property (@(posedge bus_clock) disable iff (bus_reset)
    mem_rvalid_i |-> !full);

endmodule

//--- hdl/word_packer.sv
`timescale 1ns/10ps
module word_packer
  import memreq_pkg::*;
(
  input  logic                  bus_clock,
  input  logic                  bus_reset,
  input  logic                  wb_valid_i,
  input  logic [7:0]            wb_data_i,
  input  logic                  wb_last_i,
  output logic                  wb_ready_o,
  output logic                  wd_valid_o,
  output logic [word_width-1:0] wd_data_o,
  output logic                  wd_last_o,
  input  logic                  wd_ready_i
);

  logic [1:0] cnt_q;  // Bytes already in the word
  logic full_q;
  logic last_q;
  logic [word_width-1:0] word_q;
  logic wb_fire;

  assign wb_ready_o = !full_q;  // Stall bytes while a word waits
  assign wb_fire = wb_valid_i && wb_ready_o;

  assign wd_valid_o = full_q;
  assign wd_data_o = word_q;
  assign wd_last_o = last_q;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      cnt_q <= '0;
      full_q <= 1'b0;
    end else if (wb_fire) begin
      cnt_q <= cnt_q + 2'd1;
      if (cnt_q == 2'd3)
        full_q <= 1'b1;
    end else if (full_q && wd_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // First byte ends up in bits 7:0
  always_ff @(posedge bus_clock) begin
    if (wb_fire) begin
      word_q <= {wb_data_i, word_q[word_width-1:8]};
      if (cnt_q == 2'd3)
        last_q <= wb_last_i;
    end
  end

  // Host payload must be a whole number of words
  a_last_on_word: assert property (@(posedge bus_clock) disable iff (bus_reset)
    wb_fire && wb_last_i |-> cnt_q == 2'd3);

endmodule

//--- tb.f
+incdir+verification
hdl/memreq_pkg.sv
hdl/cmd_parser.sv
hdl/word_packer.sv
hdl/mem_requester.sv
hdl/resp_framer.sv
hdl/memreq_top.sv
verification/memreq_tb.sv

//--- verification/memreq_model.svh
`ifndef MEMREQ_MODEL_SVH
`define MEMREQ_MODEL_SVH

logic [word_width-1:0] ref_mem [logic [addr_width-1:0]];
logic [7:0] exp_data [$];  // Response bytes still to come
logic exp_last [$];

// Unwritten words read back as a pattern of their own address
function automatic logic [word_width-1:0] fill_word(input logic [addr_width-1:0] addr);
  return {addr[3:0] ^ addr[27:24], addr};
endfunction

function automatic logic [word_width-1:0] ref_word(input logic [addr_width-1:0] addr);
  logic [word_width-1:0] word;
  if (ref_mem.exists(addr))
    word = ref_mem[addr];
  else
    word = fill_word(addr);
  return word;
endfunction

task automatic push_byte(input logic [7:0] data, input logic last);
  exp_data.push_back(data);
  exp_last.push_back(last);
endtask

task automatic store_beat(input logic [addr_width-1:0] addr,
                          input logic [word_width-1:0] word, input logic err);
  if (!err)
    ref_mem[addr] = word;  // Failed beats leave memory as it was
endtask

task automatic expect_write(input logic [id_width-1:0] id, input logic any_err);
  push_byte(any_err ? cmd_wfail : cmd_wdone, 1'b0);
  push_byte({{(8 - id_width){1'b0}}, id}, 1'b1);  // ID byte ends a write
endtask

task automatic expect_read(input logic [id_width-1:0] id, input logic [addr_width-1:0] addr,
                           input int nbeats, input logic first_err);
  logic [word_width-1:0] word;
  logic [addr_width-1:0] a;
  int i;
  int b;
  a = addr;
  push_byte(first_err ? cmd_rfail : cmd_rdata, 1'b0);  // Only beat 0 sets the status
  push_byte({{(8 - id_width){1'b0}}, id}, 1'b0);
  for (i = 0; i < nbeats; i++) begin
    word = ref_word(a);
    for (b = 0; b < 4; b++)
      push_byte(word[8*b +: 8], (i == nbeats - 1) && (b == 3));
    a = a + 1'b1;
  end
endtask

task automatic check_byte(input string name, input logic [7:0] actual,
                          input logic [7:0] expected);
  if (actual !== expected) begin
    $display("FAILED %s: got 0x%02h, expected 0x%02h", name, actual, expected);
    stop_with_failure();
  end
endtask

task automatic check_last(input string name, input logic actual, input logic expected);
  if (actual !== expected) begin
    $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    stop_with_failure();
  end
endtask

`endif

//--- verification/memreq_tb.sv
`timescale 1ns/10ps
module memreq_tb
  import memreq_pkg::*;
();

  localparam int num_directed = 6;
  localparam int num_random = 200;
  localparam logic [31:0] seed_base = 32'h265c;

  logic bus_clock;
  logic bus_reset;
  logic s_valid, s_last, s_ready;
  logic [7:0] s_data;
  logic m_valid, m_last, m_ready;
  logic [7:0] m_data;
  logic mem_req, mem_we, mem_gnt, mem_rvalid, mem_err;
  logic [addr_width-1:0] mem_addr;
  logic [word_width-1:0] mem_wdata, mem_rdata;

  integer stim_seed;
  integer mem_seed;
  integer rdy_seed;
  logic err_flags [$];  // Error draw per memory beat, in issue order
  logic [word_width-1:0] bus_mem [logic [addr_width-1:0]];
  logic [word_width-1:0] rsp_data [$];
  logic rsp_err [$];
  int rsp_due [$];  // Cycle at which each response may return

  `include "memreq_model.svh"

  memreq_top dut (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .s_valid_i(s_valid), .s_data_i(s_data), .s_last_i(s_last), .s_ready_o(s_ready),
    .m_valid_o(m_valid), .m_data_o(m_data), .m_last_o(m_last), .m_ready_i(m_ready),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_gnt_i(mem_gnt),
    .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata), .mem_err_i(mem_err)
  );

  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // Called on a falling edge, returns on the falling edge after the byte is taken
  task automatic send_byte(input logic [7:0] data, input logic last);
    logic taken;
    while (($random(stim_seed) & 7) == 0) begin  // Random idle gap
      s_valid = 1'b0;
      @(negedge bus_clock);
    end
    s_valid = 1'b1;
    s_data = data;
    s_last = last;
    taken = 1'b0;
    while (!taken) begin
      #1;
      taken = s_ready;
      @(negedge bus_clock);
    end
  endtask

  task automatic run_packet(input logic write, input logic [id_width-1:0] id,
                            input logic [addr_width-1:0] addr, input int nbeats,
                            input logic [15:0] err_mask);
    logic [word_width-1:0] words [16];
    logic [7:0] head [6];
    logic [addr_width-1:0] a;
    logic [beats_width-1:0] beats_m1;
    logic any_err;
    int i;
    int b;
    a = addr;
    any_err = 1'b0;
    for (i = 0; i < nbeats; i++) begin
      words[i] = $random(stim_seed);
      err_flags.push_back(err_mask[i]);
      any_err = any_err | err_mask[i];
      if (write)
        store_beat(a, words[i], err_mask[i]);
      a = a + 1'b1;
    end
    if (write)
      expect_write(id, any_err);
    else
      expect_read(id, addr, nbeats, err_mask[0]);
    beats_m1 = nbeats - 1;
    head[0] = write ? cmd_store : cmd_fetch;
    head[1] = beats_m1;
    head[2] = addr[7:0];
    head[3] = addr[15:8];
    head[4] = addr[23:16];
    head[5] = {id, addr[27:24]};
    for (i = 0; i < 6; i++)
      send_byte(head[i], !write && (i == 5));  // A FETCH ends on its header
    if (write) begin
      for (i = 0; i < nbeats; i++)
        for (b = 0; b < 4; b++)
          send_byte(words[i][8*b +: 8], (i == nbeats - 1) && (b == 3));
    end
  endtask

  initial begin
    bus_clock = 1'b0;
    forever #2 bus_clock = ~bus_clock;
  end

  initial begin
    logic [31:0] rnd;
    logic wr;
    logic [id_width-1:0] id;
    logic [addr_width-1:0] addr;
    logic [15:0] mask;
    int nbeats;
    int i;
    int b;
    stim_seed = seed_base;
    s_valid = 1'b0;
    s_data = 8'h00;
    s_last = 1'b0;
    bus_reset = 1'b1;
    repeat (2) @(posedge bus_clock);
    @(negedge bus_clock);
    if (m_valid !== 1'b0 || mem_req !== 1'b0 || s_ready !== 1'b0) begin
      $display("Stream or memory outputs are not idle during reset");
      stop_with_failure();
    end
    bus_reset = 1'b0;

    run_packet(1'b1, 4'h3, 28'h0000010, 4, 16'h0000);  // Store then read back
    run_packet(1'b0, 4'h5, 28'h0000010, 4, 16'h0000);
    run_packet(1'b1, 4'h6, 28'h0000020, 3, 16'h0002);  // WFAIL
    run_packet(1'b0, 4'h7, 28'h0000020, 4, 16'h0001);  // RFAIL, data still sent
    run_packet(1'b0, 4'h8, 28'h0000010, 4, 16'h0004);  // Late error keeps RDATA
    run_packet(1'b0, 4'h9, 28'h0000008, 16, 16'h0000);

    for (i = 0; i < num_random; i++) begin
      rnd = $random(stim_seed);
      wr = rnd[0];
      id = rnd[4:1];
      nbeats = int'(rnd[8:5]) + 1;
      addr = {22'h0, rnd[14:9]};  // Small window so packets overlap
      if (rnd[16:15] == 2'd0)
        addr[27:20] = rnd[24:17];
      for (b = 0; b < 16; b++) begin
        rnd = $random(stim_seed);
        mask[b] = (rnd[2:0] == 3'd0);
      end
      run_packet(wr, id, addr, nbeats, mask);
    end
    s_valid = 1'b0;
    s_last = 1'b0;

    while (exp_data.size() != 0)
      @(negedge bus_clock);
    repeat (20) @(negedge bus_clock);  // Catch stray trailing bytes
    if (err_flags.size() == 0 && rsp_due.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("%0d memory beats were never requested", err_flags.size());
      stop_with_failure();
    end
  end

  // Memory behind the request port
  initial begin
    logic [31:0] rnd;
    logic err;
    logic [word_width-1:0] rd;
    int cycle;
    int due;
    mem_seed = seed_base + 1;
    cycle = 0;
    mem_gnt = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    mem_err = 1'b0;
    forever begin
      @(negedge bus_clock);
      cycle++;
      rnd = $random(mem_seed);
      mem_rvalid = 1'b0;
      mem_err = 1'b0;
      if (rsp_due.size() != 0 && rsp_due[0] <= cycle) begin
        mem_rvalid = 1'b1;
        mem_rdata = rsp_data.pop_front();
        mem_err = rsp_err.pop_front();
        void'(rsp_due.pop_front());
      end
      mem_gnt = !bus_reset && (mem_req === 1'b1) && (rnd[1:0] != 2'd0);
      if (mem_gnt && err_flags.size() == 0) begin
        $display("Memory beat granted at 0x%07h with no packet beat pending", mem_addr);
        stop_with_failure();
      end else if (mem_gnt) begin
        err = err_flags.pop_front();
        rd = '0;
        if (mem_we) begin
          if (!err)
            bus_mem[mem_addr] = mem_wdata;
        end else if (bus_mem.exists(mem_addr)) begin
          rd = bus_mem[mem_addr];
        end else begin
          rd = fill_word(mem_addr);
        end
        due = cycle + 1 + int'(rnd[4:2]);
        if (rsp_due.size() != 0 && due <= rsp_due[rsp_due.size() - 1])
          due = rsp_due[rsp_due.size() - 1] + 1;  // Keep responses in order
        rsp_data.push_back(rd);
        rsp_err.push_back(err);
        rsp_due.push_back(due);
      end
    end
  end

  // Response stream with random back-pressure
  initial begin
    logic [31:0] rnd;
    logic [7:0] want_data;
    logic want_last;
    rdy_seed = seed_base + 2;
    m_ready = 1'b0;
    forever begin
      @(negedge bus_clock);
      rnd = $random(rdy_seed);
      m_ready = !bus_reset && (rnd[2:0] > 3'd2);
      #1;
      if (m_valid === 1'b1 && m_ready && exp_data.size() == 0) begin
        $display("Response byte 0x%02h arrived with none expected", m_data);
        stop_with_failure();
      end else if (m_valid === 1'b1 && m_ready) begin
        want_data = exp_data.pop_front();
        want_last = exp_last.pop_front();
        check_byte("m_data_o", m_data, want_data);
        check_last("m_last_o", m_last, want_last);
      end
    end
  end

  initial begin
    #((num_directed + num_random) * 2000);
    $display("Timeout with %0d response bytes still expected", exp_data.size());
    stop_with_failure();
  end

endmodule
